/* hw/zx_pkg.sv */
package zx_pkg;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////

	localparam int unsigned RAM_PAGE_W = 3;
	localparam int unsigned BORDER_W   = 3;

	//////////////////////////////////////////////////
	// port addresses
	//////////////////////////////////////////////////

	// ula and covox decode on the low byte only
	localparam logic [7:0]  PORT_FE_LO = 8'hFE;
	localparam logic [7:0]  PORT_FB_LO = 8'hFB;

	// paging port is fully decoded
	localparam logic [15:0] PORT_7FFD  = 16'h7FFD;

	// bit positions inside written bytes
	localparam int unsigned FE_BEEP_BIT    = 4;
	localparam int unsigned P7FFD_ROM_BIT  = 4;
	localparam int unsigned P7FFD_LOCK_BIT = 5;

	//////////////////////////////////////////////////
	// memory map
	//////////////////////////////////////////////////

	// fixed ram in 0x4000 and 0x8000 windows
	localparam logic [RAM_PAGE_W-1:0] PAGE_WIN1 = 3'd5;
	localparam logic [RAM_PAGE_W-1:0] PAGE_WIN2 = 3'd2;

	// m1 in 0x3Dxx enters trdos
	localparam logic [7:0] TRDOS_HI = 8'h3D;

	// one synchronized z80 bus event
	typedef struct packed {
		logic        io_wr;
		logic        m1_fetch;
		logic [15:0] addr;
		logic [7:0]  data;
	} z80_evt_t;

	// mapping of the current address
	typedef struct packed {
		logic                  is_rom;
		logic [1:0]            rom_page;
		logic [RAM_PAGE_W-1:0] ram_page;
	} mem_sel_t;

endpackage

/* hw/reset_stretch.sv */
module reset_stretch
#(
	parameter int unsigned RST_CNT_SIZE = 4
)
(
	input  logic fclk,
	input  logic rst,
	output logic core_rst
);

	logic [RST_CNT_SIZE-1:0] cnt;

	// reload while rst is up, then count down to zero
	// core_rst drops one cycle after the count is spent
	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			cnt      <= '1;
			core_rst <= 1'b1;
		end
		else if (cnt != '0)
		begin
			cnt <= cnt - 1'b1;
		end
		else
		begin
			core_rst <= 1'b0;
		end
	end

endmodule

/* hw/z80_bus_sync.sv */
module z80_bus_sync
#(
	parameter int unsigned SYNC_STAGES = 2
)
(
	input  logic             fclk,
	input  logic             core_rst,
	input  logic             iorq_n,
	input  logic             mreq_n,
	input  logic             rd_n,
	input  logic             wr_n,
	input  logic             m1_n,
	input  logic [15:0]      a,
	input  logic [7:0]       d,
	output zx_pkg::z80_evt_t evt
);

	logic [4:0]  strb_q [SYNC_STAGES];
	logic [23:0] bus_q  [SYNC_STAGES];

	logic iorq_s, mreq_s, rd_s, wr_s, m1_s;
	logic io_wr_lvl, m1_lvl;
	logic io_wr_prev, m1_prev;
	logic io_wr_q, m1_q;
	logic [15:0] addr_q;
	logic [7:0]  data_q;

	//////////////////////////////////////////////////
	// synchronizer chains
	//////////////////////////////////////////////////

	// strobes idle high
	always_ff @(posedge fclk)
	begin
		if (core_rst)
		begin
			for (int i = 0; i < SYNC_STAGES; i++)
				strb_q[i] <= '1;
		end
		else
		begin
			strb_q[0] <= {iorq_n, mreq_n, rd_n, wr_n, m1_n};
			for (int i = 1; i < SYNC_STAGES; i++)
				strb_q[i] <= strb_q[i-1];
		end
	end

	// address and data follow the same stages
	always_ff @(posedge fclk)
	begin
		bus_q[0] <= {a, d};
		for (int i = 1; i < SYNC_STAGES; i++)
			bus_q[i] <= bus_q[i-1];
	end

	assign {iorq_s, mreq_s, rd_s, wr_s, m1_s} = strb_q[SYNC_STAGES-1];

	assign io_wr_lvl = ~iorq_s & ~wr_s;
	assign m1_lvl    = ~mreq_s & ~m1_s & ~rd_s;

	//////////////////////////////////////////////////
	// one pulse per bus cycle
	//////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (core_rst)
		begin
			io_wr_prev <= 1'b0;
			m1_prev    <= 1'b0;
			io_wr_q    <= 1'b0;
			m1_q       <= 1'b0;
		end
		else
		begin
			io_wr_prev <= io_wr_lvl;
			m1_prev    <= m1_lvl;
			io_wr_q    <= io_wr_lvl & ~io_wr_prev;
			m1_q       <= m1_lvl & ~m1_prev;
		end
	end

	always_ff @(posedge fclk)
	begin
		{addr_q, data_q} <= bus_q[SYNC_STAGES-1];
	end

	always_comb
	begin
		evt.io_wr    = io_wr_q;
		evt.m1_fetch = m1_q;
		evt.addr     = addr_q;
		evt.data     = data_q;
	end

endmodule

/* hw/ula_ports.sv */
module ula_ports
(
	input  logic                        fclk,
	input  logic                        core_rst,
	input  zx_pkg::z80_evt_t            evt,
	output logic [zx_pkg::BORDER_W-1:0] border,
	output logic                        beep,
	output logic [7:0]                  covox_smp
);

	import zx_pkg::*;

	logic fe_wr;
	logic fb_wr;

	// high address byte is don't care
	assign fe_wr = evt.io_wr && (evt.addr[7:0] == PORT_FE_LO);
	assign fb_wr = evt.io_wr && (evt.addr[7:0] == PORT_FB_LO);

	//////////////////////////////////////////////////
	// border and beeper on port 0xFE
	//////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (core_rst)
		begin
			border <= '0;
			beep   <= 1'b0;
		end
		else if (fe_wr)
		begin
			border <= evt.data[BORDER_W-1:0];
			beep   <= evt.data[FE_BEEP_BIT];
		end
	end

	//////////////////////////////////////////////////
	// covox sample on port 0xFB
	//////////////////////////////////////////////////

	// whole byte goes to the dac
	always_ff @(posedge fclk)
	begin
		if (core_rst)
		begin
			covox_smp <= '0;
		end
		else if (fb_wr)
		begin
			covox_smp <= evt.data;
		end
	end

endmodule

/* hw/mem_pager.sv */
module mem_pager
(
	input  logic             fclk,
	input  logic             core_rst,
	input  zx_pkg::z80_evt_t evt,
	input  logic [15:0]      a,
	input  logic             dos,
	output logic             rom_sel,
	output zx_pkg::mem_sel_t mem_sel,
	output logic             csrom
);

	import zx_pkg::*;

	logic [RAM_PAGE_W-1:0] ram_page_q;
	logic                  lock_q;
	logic                  wr_7ffd;

	//////////////////////////////////////////////////
	// 0x7FFD register
	//////////////////////////////////////////////////

	// full 16-bit decode and no writes once locked
	assign wr_7ffd = evt.io_wr && (evt.addr == PORT_7FFD) && !lock_q;

	always_ff @(posedge fclk)
	begin
		if (core_rst)
		begin
			ram_page_q <= '0;
			rom_sel    <= 1'b0;
			lock_q     <= 1'b0;
		end
		else if (wr_7ffd)
		begin
			ram_page_q <= evt.data[RAM_PAGE_W-1:0];
			rom_sel    <= evt.data[P7FFD_ROM_BIT];
			lock_q     <= evt.data[P7FFD_LOCK_BIT];
		end
	end

	//////////////////////////////////////////////////
	// window mapping
	//////////////////////////////////////////////////

	// unused fields read zero
	always_comb
	begin
		mem_sel = '0;
		case (a[15:14])
			2'd0:
			begin
				mem_sel.is_rom   = 1'b1;
				// dos picks the trdos/basic48 pair
				mem_sel.rom_page = {dos, rom_sel};
			end
			2'd1:
			begin
				mem_sel.ram_page = PAGE_WIN1;
			end
			2'd2:
			begin
				mem_sel.ram_page = PAGE_WIN2;
			end
			default:
			begin
				mem_sel.ram_page = ram_page_q;
			end
		endcase
	end

	assign csrom = mem_sel.is_rom;

endmodule

/* hw/dos_ctl.sv */
module dos_ctl
(
	input  logic             fclk,
	input  logic             core_rst,
	input  zx_pkg::z80_evt_t evt,
	input  logic             rom_sel,
	output logic             dos,
	output logic             dos_n
);

	import zx_pkg::*;

	logic dos_on;
	logic dos_off;

	// entry only from the basic48 rom
	assign dos_on  = evt.m1_fetch && (evt.addr[15:8] == TRDOS_HI) && rom_sel;

	// any fetch outside the rom window leaves dos
	assign dos_off = evt.m1_fetch && (evt.addr[15:14] != 2'b00);

	always_ff @(posedge fclk)
	begin
		if (core_rst)
		begin
			dos <= 1'b0;
		end
		else if (dos_on)
		begin
			dos <= 1'b1;
		end
		else if (dos_off)
		begin
			dos <= 1'b0;
		end
	end

	assign dos_n = ~dos;

endmodule

/* hw/covox_dac.sv */
module covox_dac
(
	input  logic       fclk,
	input  logic       core_rst,
	input  logic [7:0] covox_smp,
	output logic       covox_out
);

	logic [7:0] acc;
	logic [8:0] sum;

	// first order sigma-delta
	// carry density equals sample/256
	assign sum = {1'b0, acc} + {1'b0, covox_smp};

	always_ff @(posedge fclk)
	begin
		if (core_rst)
		begin
			acc       <= '0;
			covox_out <= 1'b0;
		end
		else
		begin
			acc       <= sum[7:0];
			covox_out <= sum[8];
		end
	end

endmodule

/* hw/zx_core_top.sv */
module zx_core_top
#(
	parameter int unsigned RST_CNT_SIZE = 4,
	parameter int unsigned SYNC_STAGES  = 2
)
(
	input  logic                        fclk,
	input  logic                        rst,

	// z80 bus
	input  logic                        iorq_n,
	input  logic                        mreq_n,
	input  logic                        rd_n,
	input  logic                        wr_n,
	input  logic                        m1_n,
	input  logic [15:0]                 a,
	input  logic [7:0]                  d,

	// ula and sound
	output logic [zx_pkg::BORDER_W-1:0] border,
	output logic                        beep,
	output logic                        covox_out,

	// memory select
	output zx_pkg::mem_sel_t            mem_sel,
	output logic                        csrom,
	output logic                        dos_n
);

	import zx_pkg::*;

	logic       core_rst;
	z80_evt_t   evt;
	logic       rom_sel;
	logic       dos;
	logic [7:0] covox_smp;

	reset_stretch #(.RST_CNT_SIZE(RST_CNT_SIZE)) i_reset_stretch
	(
		.fclk     (fclk),
		.rst      (rst),
		.core_rst (core_rst)
	);

	z80_bus_sync #(.SYNC_STAGES(SYNC_STAGES)) i_z80_bus_sync
	(
		.fclk     (fclk),
		.core_rst (core_rst),
		.iorq_n   (iorq_n),
		.mreq_n   (mreq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.a        (a),
		.d        (d),
		.evt      (evt)
	);

	ula_ports i_ula_ports
	(
		.fclk      (fclk),
		.core_rst  (core_rst),
		.evt       (evt),
		.border    (border),
		.beep      (beep),
		.covox_smp (covox_smp)
	);

	//////////////////////////////////////////////////
	// paging and dos rom
	//////////////////////////////////////////////////

	mem_pager i_mem_pager
	(
		.fclk     (fclk),
		.core_rst (core_rst),
		.evt      (evt),
		.a        (a),
		.dos      (dos),
		.rom_sel  (rom_sel),
		.mem_sel  (mem_sel),
		.csrom    (csrom)
	);

	dos_ctl i_dos_ctl
	(
		.fclk     (fclk),
		.core_rst (core_rst),
		.evt      (evt),
		.rom_sel  (rom_sel),
		.dos      (dos),
		.dos_n    (dos_n)
	);

	covox_dac i_covox_dac
	(
		.fclk      (fclk),
		.core_rst  (core_rst),
		.covox_smp (covox_smp),
		.covox_out (covox_out)
	);

endmodule

/* sim/tb_zx_tasks.svh */
//////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////

task automatic abort_run();
	$display("Simulation FAILED");
	$fatal(1, "stopped at the first mismatch");
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp)
	begin
		$display("ERROR at time %0t: %s expected %b, actual %b", $time, name, exp, act);
		abort_run();
	end
endtask

task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
	if (act !== exp)
	begin
		$display("ERROR at time %0t: %s expected %0h, actual %0h", $time, name, exp, act);
		abort_run();
	end
endtask

task automatic check_mem_sel(input string name, input mem_sel_t exp, input mem_sel_t act);
	if (act !== exp)
	begin
		$display("ERROR at time %0t: %s expected rom %b/%0d ram %0d, actual rom %b/%0d ram %0d",
			$time, name, exp.is_rom, exp.rom_page, exp.ram_page,
			act.is_rom, act.rom_page, act.ram_page);
		abort_run();
	end
endtask

// expected mapping of a rom or a ram window
function automatic mem_sel_t rom_win(input logic [1:0] page);
	mem_sel_t s;
	s          = '0;
	s.is_rom   = 1'b1;
	s.rom_page = page;
	return s;
endfunction

function automatic mem_sel_t ram_win(input logic [2:0] page);
	mem_sel_t s;
	s          = '0;
	s.ram_page = page;
	return s;
endfunction

//////////////////////////////////////////////////
// bus drivers
//////////////////////////////////////////////////

task automatic pulse_reset();
	@(posedge fclk);
	rst <= 1'b1;
	repeat (RST_CYC) @(posedge fclk);
	rst <= 1'b0;
	repeat (RST_WAIT) @(posedge fclk);
	@(negedge fclk);
endtask

// each driver returns on a falling edge with outputs stable
task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
	@(posedge fclk);
	a      <= addr;
	d      <= data;
	iorq_n <= 1'b0;
	wr_n   <= 1'b0;
	repeat (BUS_HOLD) @(posedge fclk);
	iorq_n <= 1'b1;
	wr_n   <= 1'b1;
	repeat (BUS_IDLE) @(posedge fclk);
	@(negedge fclk);
endtask

task automatic m1_fetch(input logic [15:0] addr);
	@(posedge fclk);
	a      <= addr;
	mreq_n <= 1'b0;
	m1_n   <= 1'b0;
	rd_n   <= 1'b0;
	repeat (BUS_HOLD) @(posedge fclk);
	mreq_n <= 1'b1;
	m1_n   <= 1'b1;
	rd_n   <= 1'b1;
	repeat (BUS_IDLE) @(posedge fclk);
	@(negedge fclk);
endtask

// mapping is combinational from the live address
task automatic probe_window(input logic [15:0] addr, input mem_sel_t exp);
	@(posedge fclk);
	a <= addr;
	@(negedge fclk);
	check_mem_sel("mem_sel", exp, mem_sel);
	check_bit("csrom", exp.is_rom, csrom);
endtask

//////////////////////////////////////////////////
// tests
//////////////////////////////////////////////////

task automatic test_after_reset();
	check_byte("border", 8'h00, {5'b0, border});
	check_bit("beep", 1'b0, beep);
	check_bit("dos_n", 1'b1, dos_n);
	repeat (DAC_WIN)
	begin
		@(negedge fclk);
		check_bit("covox_out", 1'b0, covox_out);
	end
	probe_window(16'hC000, ram_win(3'd0));
	probe_window(16'h0000, rom_win(2'd0));
endtask

task automatic test_port_fe();
	logic [31:0] rnd;
	logic [7:0]  hi;
	logic [7:0]  data;
	logic [2:0]  exp_border;
	logic        exp_beep;
	for (int i = 0; i < 4; i++)
	begin
		rnd        = $random(seed);
		hi         = rnd[15:8];
		data       = rnd[7:0];
		exp_border = data[2:0];
		exp_beep   = data[4];
		io_write({hi, 8'hFE}, data);
		check_byte("border", {5'b0, exp_border}, {5'b0, border});
		check_bit("beep", exp_beep, beep);
	end
	// another low byte is not the ula
	io_write({hi, 8'hFC}, ~data);
	check_byte("border", {5'b0, exp_border}, {5'b0, border});
	check_bit("beep", exp_beep, beep);
endtask

task automatic test_paging();
	// page 3 with rom select 1
	io_write(16'h7FFD, 8'h13);
	probe_window(16'h0123, rom_win(2'd1));
	probe_window(16'h4567, ram_win(3'd5));
	probe_window(16'h89AB, ram_win(3'd2));
	probe_window(16'hCDEF, ram_win(3'd3));
	// page 6 with rom select and lock before an ignored write
	io_write(16'h7FFD, 8'h36);
	io_write(16'h7FFD, 8'h01);
	probe_window(16'hC000, ram_win(3'd6));
	probe_window(16'h0000, rom_win(2'd1));
	pulse_reset();
	probe_window(16'hC000, ram_win(3'd0));
	probe_window(16'h0000, rom_win(2'd0));
	// lock gone after reset
	io_write(16'h7FFD, 8'h07);
	probe_window(16'hFFFF, ram_win(3'd7));
endtask

task automatic test_dos();
	m1_fetch(16'h3D2F);
	check_bit("dos_n", 1'b1, dos_n);
	io_write(16'h7FFD, 8'h10);
	m1_fetch(16'h3D2F);
	check_bit("dos_n", 1'b0, dos_n);
	probe_window(16'h0000, rom_win(2'd3));
	m1_fetch(16'h8000);
	check_bit("dos_n", 1'b1, dos_n);
	probe_window(16'h0000, rom_win(2'd1));
endtask

// ones in 256 cycles must equal the sample
task automatic covox_window(input logic [7:0] smp);
	logic [31:0] rnd;
	int          cnt;
	rnd = $random(seed);
	io_write({rnd[7:0], 8'hFB}, smp);
	repeat (4) @(negedge fclk);
	cnt = 0;
	repeat (DAC_WIN)
	begin
		@(negedge fclk);
		if (covox_out)
			cnt++;
	end
	check_bit("covox_out count overflow", 1'b0, cnt > 255);
	check_byte("covox_out count", smp, cnt[7:0]);
endtask

task automatic test_covox();
	covox_window(8'h00);
	covox_window(8'h01);
	covox_window(8'h80);
	covox_window(8'hFF);
	covox_window(8'h5A);
endtask

/* sim/tb_zx_core.sv */
module tb_zx_core;

	import zx_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RST_CYC    = 4;
	// stretched core reset of 16 cycles plus spare
	localparam int RST_WAIT   = 20;
	localparam int BUS_HOLD   = 6;
	localparam int BUS_IDLE   = 2;
	localparam int DAC_WIN    = 256;

	// rough cycle budget of the whole test sequence
	localparam int N_BUS      = 20;
	localparam int N_PROBE    = 16;
	localparam int N_WIN      = 6;
	localparam int N_RST      = 2;
	localparam int TEST_CYC   = N_BUS * (BUS_HOLD + BUS_IDLE + 1) + N_PROBE * 2
		+ N_WIN * (DAC_WIN + 5) + N_RST * (RST_CYC + RST_WAIT + 1);
	localparam int WATCHDOG_TIME = 2 * TEST_CYC * CLK_PERIOD;

	logic                fclk = 1'b0;
	logic                rst;
	logic                iorq_n;
	logic                mreq_n;
	logic                rd_n;
	logic                wr_n;
	logic                m1_n;
	logic [15:0]         a;
	logic [7:0]          d;
	logic [BORDER_W-1:0] border;
	logic                beep;
	logic                covox_out;
	mem_sel_t            mem_sel;
	logic                csrom;
	logic                dos_n;

	integer seed = 32'h925c_53de;

	always #(CLK_PERIOD / 2) fclk = ~fclk;

	zx_core_top #(.RST_CNT_SIZE(4), .SYNC_STAGES(2)) i_dut
	(
		.fclk      (fclk),
		.rst       (rst),
		.iorq_n    (iorq_n),
		.mreq_n    (mreq_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.m1_n      (m1_n),
		.a         (a),
		.d         (d),
		.border    (border),
		.beep      (beep),
		.covox_out (covox_out),
		.mem_sel   (mem_sel),
		.csrom     (csrom),
		.dos_n     (dos_n)
	);

	`include "tb_zx_tasks.svh"

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial
	begin
		// bus idles with all strobes high
		rst    <= 1'b1;
		iorq_n <= 1'b1;
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		m1_n   <= 1'b1;
		a      <= '0;
		d      <= '0;

		pulse_reset();

		test_after_reset();
		test_port_fe();
		test_paging();
		test_dos();
		test_covox();

		$display("Simulation PASSED");
		$finish;
	end

	//////////////////////////////////////////////////
	// watchdog
	//////////////////////////////////////////////////

	initial
	begin
		#(WATCHDOG_TIME);
		$display("timeout: the tests did not finish within %0d time units", WATCHDOG_TIME);
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

/* filelist.f */
+incdir+sim
hw/zx_pkg.sv
hw/reset_stretch.sv
hw/z80_bus_sync.sv
hw/ula_ports.sv
hw/mem_pager.sv
hw/dos_ctl.sv
hw/covox_dac.sv
hw/zx_core_top.sv
sim/tb_zx_core.sv

/* Bender.yml */
package:
  name: zx_core

sources:
  # rtl, package first
  - hw/zx_pkg.sv
  - hw/reset_stretch.sv
  - hw/z80_bus_sync.sv
  - hw/ula_ports.sv
  - hw/mem_pager.sv
  - hw/dos_ctl.sv
  - hw/covox_dac.sv
  - hw/zx_core_top.sv

  # testbench
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_zx_core.sv
